// ==== common/ofdm_status_pkg.sv ====
// OFDM receiver event bundle and the accumulated user status word layout
`default_nettype none

package ofdm_status_pkg;

   //////////////////////////////
   // receiver events, flags are single-cycle strobes
   typedef struct packed {
      logic        power_trigger;
      logic        short_preamble;
      logic        long_preamble;
      logic        pkt_begin;
      logic        pkt_ht;
      logic        fcs_stb;
      logic        fcs_ok;     // valid with fcs_stb
      logic        byte_stb;   // rate and len valid here
      logic [3:0]  rx_state;
      logic [3:0]  status_code;
      logic [7:0]  pkt_rate;
      logic [15:0] pkt_len;
   } ofdm_event_t;

   //////////////////////////////
   // status word, byte 0 flags
   typedef struct packed {
      logic run_rx;
      logic fcs_good;
      logic fcs_seen;
      logic ht;
      logic pkt_begin;
      logic power_trigger;
      logic short_pre;
      logic long_pre;
   } status_flags_t;

   typedef struct packed {
      logic [23:0]   reserved;   // always zero
      logic [7:0]    pkt_rate;   // 39:32
      logic [15:0]   pkt_len;    // 31:16
      logic [3:0]    max_code;   // 15:12
      logic [3:0]    max_state;  // 11:8
      status_flags_t flags;      // 7:0
   } ofdm_status_t;

   // bit of user reg0 that holds the status word in clear
   localparam int status_clear_bit = 0;

endpackage

`default_nettype wire

// ==== common/radio_regs_pkg.sv ====
// settings bus layout, register map and time types shared by the control side of the radio
`default_nettype none

package radio_regs_pkg;

   //////////////////////////////
   // settings bus
   typedef struct packed {
      logic        stb;   // one-cycle write strobe
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // register map
   localparam logic [7:0] sr_test         = 8'd21;
   localparam logic [7:0] sr_readback     = 8'd32;
   localparam logic [7:0] sr_time_hi      = 8'd128;
   localparam logic [7:0] sr_time_lo      = 8'd129;
   localparam logic [7:0] sr_time_ctrl    = 8'd130;
   localparam logic [7:0] sr_user_reg0    = 8'd253;
   localparam logic [7:0] sr_user_rb_addr = 8'd255;

   //////////////////////////////
   // readback selectors
   typedef logic [2:0] rb_sel_t;

   localparam rb_sel_t rb_test     = 3'd0;
   localparam rb_sel_t rb_time     = 3'd1;
   localparam rb_sel_t rb_time_pps = 3'd2;
   localparam rb_sel_t rb_user     = 3'd7;  // 3..5 have nothing behind them

   typedef logic [7:0] user_rb_sel_t;

   localparam user_rb_sel_t urb_reg0   = 8'd0;
   localparam user_rb_sel_t urb_status = 8'd1;

   //////////////////////////////
   // time control
   typedef struct packed {
      logic now;     // load on the next edge
      logic at_pps;  // arm, load on the next pps rise
      logic stb;
   } time_cmd_t;

   typedef logic [63:0] time_t;

endpackage

`default_nettype wire

// ==== hdl/radio_ctrl_top.sv ====
// radio control top, ties settings decode, timekeeper, status accumulator and readback together
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_top import radio_regs_pkg::*, ofdm_status_pkg::*; (
   input  wire         bus_clk,
   input  wire         i_rst_n,
   input  set_bus_t    i_set,
   input  wire         i_pps,
   input  wire         i_run_rx,
   input  ofdm_event_t i_event,
   output logic [63:0] o_rb_data,
   output time_t       o_vita_time
);

   //////////////////////////////
   // interconnect
   logic [31:0]  test_reg;
   rb_sel_t      rb_sel;
   user_rb_sel_t user_rb_sel;
   logic [31:0]  user_reg0;
   time_cmd_t    time_cmd;
   time_t        time_load;
   time_t        time_last_pps;
   ofdm_status_t status;

   settings_decode settings_decode_i (
      .bus_clk       (bus_clk),
      .i_rst_n       (i_rst_n),
      .i_set         (i_set),
      .o_test_reg    (test_reg),
      .o_rb_sel      (rb_sel),
      .o_user_rb_sel (user_rb_sel),
      .o_user_reg0   (user_reg0),
      .o_time_cmd    (time_cmd),
      .o_time_load   (time_load)
   );

   radio_timekeeper radio_timekeeper_i (
      .bus_clk         (bus_clk),
      .i_rst_n         (i_rst_n),
      .i_time_cmd      (time_cmd),
      .i_time_load     (time_load),
      .i_pps           (i_pps),
      .o_vita_time     (o_vita_time),
      .o_time_last_pps (time_last_pps)
   );

   ofdm_status_accum ofdm_status_accum_i (
      .bus_clk  (bus_clk),
      .i_rst_n  (i_rst_n),
      .i_clear  (user_reg0[status_clear_bit]),  // software clear
      .i_run_rx (i_run_rx),
      .i_event  (i_event),
      .o_status (status)
   );

   readback_select readback_select_i (
      .i_rb_sel        (rb_sel),
      .i_user_rb_sel   (user_rb_sel),
      .i_test_reg      (test_reg),
      .i_vita_time     (o_vita_time),
      .i_time_last_pps (time_last_pps),
      .i_user_reg0     (user_reg0),
      .i_status        (status),
      .o_rb_data       (o_rb_data)
   );

endmodule

`default_nettype wire

// ==== hdl/radio_timekeeper.sv ====
// free-running 64-bit radio time, loadable now or at the next pps, latched on every pps rise
`timescale 1ns/1ps
`default_nettype none

module radio_timekeeper import radio_regs_pkg::*; (
   input  wire       bus_clk,
   input  wire       i_rst_n,
   input  time_cmd_t i_time_cmd,
   input  time_t     i_time_load,
   input  wire       i_pps,
   output time_t     o_vita_time,
   output time_t     o_time_last_pps
);

   logic pps_r;     // registered pps
   logic pps_prev;  // one cycle older
   logic pps_rise;
   logic armed;     // waiting for pps to load
   logic load_now;

   assign pps_rise = pps_r && !pps_prev;
   assign load_now = i_time_cmd.stb && i_time_cmd.now;

   //////////////////////////////
   // pps edge detect
   always_ff @(posedge bus_clk) begin
      if (!i_rst_n) begin
         pps_r    <= 1'b0;
         pps_prev <= 1'b0;
      end else begin
         pps_r    <= i_pps;
         pps_prev <= pps_r;
      end
   end

   //////////////////////////////
   // counter and armed load
   always_ff @(posedge bus_clk) begin
      if (!i_rst_n) begin
         o_vita_time <= '0;
         armed       <= 1'b0;
      end else begin
         if (load_now) begin
            o_vita_time <= i_time_load;
         end else if (pps_rise && armed) begin
            o_vita_time <= i_time_load;
         end else begin
            o_vita_time <= o_vita_time + 64'd1;
         end

         // an immediate load wins over arming
         if (i_time_cmd.stb && i_time_cmd.at_pps && !i_time_cmd.now)
            armed <= 1'b1;
         else if (pps_rise)
            armed <= 1'b0;
      end
   end

   // time seen just before the pps edge
   always_ff @(posedge bus_clk) begin
      if (!i_rst_n)
         o_time_last_pps <= '0;
      else if (pps_rise)
         o_time_last_pps <= o_vita_time;
   end

endmodule

`default_nettype wire

// ==== hdl/readback_select.sv ====
// two-level combinational readback mux, user selector under main selector code 7
`timescale 1ns/1ps
`default_nettype none

module readback_select import radio_regs_pkg::*, ofdm_status_pkg::*; (
   input  rb_sel_t      i_rb_sel,
   input  user_rb_sel_t i_user_rb_sel,
   input  wire [31:0]   i_test_reg,
   input  time_t        i_vita_time,
   input  time_t        i_time_last_pps,
   input  wire [31:0]   i_user_reg0,
   input  ofdm_status_t i_status,
   output logic [63:0]  o_rb_data
);

   logic [63:0] user_data;

   // user level
   always_comb begin
      case (i_user_rb_sel)
         urb_reg0:   user_data = {32'd0, i_user_reg0};
         urb_status: user_data = i_status;
         default:    user_data = '0;
      endcase
   end

   // main level
   always_comb begin
      case (i_rb_sel)
         rb_test:     o_rb_data = {32'd0, i_test_reg};
         rb_time:     o_rb_data = i_vita_time;
         rb_time_pps: o_rb_data = i_time_last_pps;
         rb_user:     o_rb_data = user_data;
         default:     o_rb_data = '0;  // samples, gpio, rx state
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/settings_decode.sv ====
// settings bus decoder, turns strobed writes into config registers and the time-load command
`timescale 1ns/1ps
`default_nettype none

module settings_decode import radio_regs_pkg::*; (
   input  wire          bus_clk,
   input  wire          i_rst_n,
   input  set_bus_t     i_set,
   output logic [31:0]  o_test_reg,
   output rb_sel_t      o_rb_sel,
   output user_rb_sel_t o_user_rb_sel,
   output logic [31:0]  o_user_reg0,
   output time_cmd_t    o_time_cmd,
   output time_t        o_time_load
);

   logic [31:0] time_hi;
   logic [31:0] time_lo;
   logic        wr_ctrl;

   assign wr_ctrl = i_set.stb && (i_set.addr == sr_time_ctrl);

   //////////////////////////////
   // register writes
   always_ff @(posedge bus_clk) begin
      if (!i_rst_n) begin
         o_test_reg    <= '0;
         o_rb_sel      <= '0;
         o_user_rb_sel <= '0;
         o_user_reg0   <= '0;
         time_hi       <= '0;
         time_lo       <= '0;
      end else if (i_set.stb) begin
         case (i_set.addr)
            sr_test:         o_test_reg    <= i_set.data;
            sr_readback:     o_rb_sel      <= i_set.data[2:0];
            sr_user_rb_addr: o_user_rb_sel <= i_set.data[7:0];
            sr_user_reg0:    o_user_reg0   <= i_set.data;
            sr_time_hi:      time_hi       <= i_set.data;
            sr_time_lo:      time_lo       <= i_set.data;
            default: ;  // not ours
         endcase
      end
   end

   //////////////////////////////
   // time command, strobe lasts one cycle
   always_ff @(posedge bus_clk) begin
      if (!i_rst_n) begin
         o_time_cmd <= '0;
      end else begin
         o_time_cmd.stb <= wr_ctrl;
         if (wr_ctrl) begin
            o_time_cmd.now    <= i_set.data[0];
            o_time_cmd.at_pps <= i_set.data[1];
         end
      end
   end

   assign o_time_load = {time_hi, time_lo};  // staged load value

endmodule

`default_nettype wire

// ==== ofdm_status/ofdm_status_accum.sv ====
// gathers OFDM receiver events into the sticky user status word, held clear by user reg0
`timescale 1ns/1ps
`default_nettype none

module ofdm_status_accum import ofdm_status_pkg::*; (
   input  wire          bus_clk,
   input  wire          i_rst_n,
   input  wire          i_clear,
   input  wire          i_run_rx,
   input  ofdm_event_t  i_event,
   output ofdm_status_t o_status
);

   status_flags_t new_flags;

   // flags seen this cycle
   always_comb begin
      new_flags.run_rx        = i_run_rx;
      new_flags.fcs_good      = i_event.fcs_stb && i_event.fcs_ok;
      new_flags.fcs_seen      = i_event.fcs_stb;
      new_flags.ht            = i_event.pkt_ht;
      new_flags.pkt_begin     = i_event.pkt_begin;
      new_flags.power_trigger = i_event.power_trigger;
      new_flags.short_pre     = i_event.short_preamble;
      new_flags.long_pre      = i_event.long_preamble;
   end

   //////////////////////////////
   // accumulate
   always_ff @(posedge bus_clk) begin
      if (!i_rst_n || i_clear) begin
         o_status <= '0;
      end else begin
         o_status.flags <= o_status.flags | new_flags;  // sticky

         // highest values only
         if (i_event.rx_state > o_status.max_state)
            o_status.max_state <= i_event.rx_state;
         if (i_event.status_code > o_status.max_code)
            o_status.max_code <= i_event.status_code;

         if (i_event.byte_stb) begin
            o_status.pkt_rate <= i_event.pkt_rate;
            o_status.pkt_len  <= i_event.pkt_len;
         end
      end
   end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the radio control testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module radio_ctrl_tb \
   -f sources.f \
   -o radio_ctrl_sim

./obj_dir/radio_ctrl_sim > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
   echo "simulation reported errors, see sim.log"
   exit 1
fi

echo "simulation finished without errors"
exit 0

// ==== sources.f ====
common/radio_regs_pkg.sv
common/ofdm_status_pkg.sv
hdl/settings_decode.sv
hdl/radio_timekeeper.sv
ofdm_status/ofdm_status_accum.sv
hdl/readback_select.sv
hdl/radio_ctrl_top.sv
tb/radio_ctrl_tb.sv

// ==== tb/radio_ctrl_tb.sv ====
// testbench for the radio control top that replays the steps in tb/radio_ctrl_tests.txt
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_tb import radio_regs_pkg::*, ofdm_status_pkg::*; ();

   localparam string tests_file    = "tb/radio_ctrl_tests.txt";
   localparam int    reset_cycles  = 8;
   localparam int    margin_cycles = 50;

   logic        bus_clk;
   logic        i_rst_n;
   set_bus_t    i_set;
   logic        i_pps;
   logic        i_run_rx;
   ofdm_event_t i_event;
   logic [63:0] o_rb_data;
   time_t       o_vita_time;

   // fields of the current step
   logic [7:0]       cmd;
   logic [63:0]      a0, a1, a2, a3, a4, a5;
   logic [8*120-1:0] rest;

   int errors      = 0;
   int checks      = 0;
   int cycle_limit = 0;
   int cycle_count = 0;

   radio_ctrl_top radio_ctrl_top_i (
      .bus_clk     (bus_clk),
      .i_rst_n     (i_rst_n),
      .i_set       (i_set),
      .i_pps       (i_pps),
      .i_run_rx    (i_run_rx),
      .i_event     (i_event),
      .o_rb_data   (o_rb_data),
      .o_vita_time (o_vita_time)
   );

   initial begin
      bus_clk = 1'b0;
      forever #20 bus_clk = ~bus_clk;  // 40 ns period
   end

   //////////////////////////////
   // file reading
   task automatic read_step(input int fd, output bit got);
      int code;
      got  = 1'b0;
      code = $fscanf(fd, "%s", cmd);
      if (code == 1) begin
         got = 1'b1;
         case (cmd)
            "w":      code = $fscanf(fd, "%h %h", a0, a1);
            "e":      code = $fscanf(fd, "%h %h %h %h %h %h", a0, a1, a2, a3, a4, a5);
            "p", "i": code = $fscanf(fd, "%h", a0);
            "c":      code = $fscanf(fd, "%h %h %h", a0, a1, a2);
            "#":      code = $fgets(rest, fd);  // comment line
            default: ;
         endcase
      end
   endtask

   // clock cycles a step takes
   function automatic int step_cost();
      case (cmd)
         "w", "e", "p": return 1;
         "i":           return int'(a0[15:0]);
         "c":           return 2;  // two selector writes
         default:       return 0;
      endcase
   endfunction

   task automatic count_budget(output bit ok);
      int fd;
      int total;
      bit got;
      fd    = $fopen(tests_file, "r");
      ok    = (fd != 0);
      got   = ok;
      total = reset_cycles + margin_cycles;
      while (got) begin
         read_step(fd, got);
         if (got)
            total += step_cost();
      end
      if (ok)
         $fclose(fd);
      cycle_limit = total;
   endtask

   //////////////////////////////
   // bus actions entered and left on a falling edge
   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      i_set = {1'b1, addr, data};
      @(negedge bus_clk);
      i_set = '0;
   endtask

   task automatic apply_event();
      i_event  = {a0[7:0], a1[3:0], a2[3:0], a3[7:0], a4[15:0]};
      i_run_rx = a5[0];  // run_rx is a level and stays
      @(negedge bus_clk);
      i_event = '0;
   endtask

   task automatic check_readback(input logic [2:0] sel, input logic [7:0] usel,
                                 input logic [63:0] expected);
      write_reg(sr_readback, {29'd0, sel});
      write_reg(sr_user_rb_addr, {24'd0, usel});
      checks++;
      assert (o_rb_data == expected)
      else begin
         $display("Fail o_rb_data sel %h user %h expected %h actual %h",
                  sel, usel, expected, o_rb_data);
         errors++;
      end
      // the time output carries the same value as the rb_time readback
      if (sel == rb_time) begin
         checks++;
         assert (o_vita_time == expected)
         else begin
            $display("Fail o_vita_time expected %h actual %h", expected, o_vita_time);
            errors++;
         end
      end
   endtask

   task automatic run_step();
      case (cmd)
         "w": write_reg(a0[7:0], a1[31:0]);
         "e": apply_event();
         "p": begin
            i_pps = a0[0];
            @(negedge bus_clk);
         end
         "i": repeat (a0[15:0]) @(negedge bus_clk);
         "c": check_readback(a0[2:0], a1[7:0], a2);
         "#": ;
         default: begin
            $display("unknown command '%s' in the test file", cmd);
            errors++;
         end
      endcase
   endtask

   task automatic finish_run();
      $display("closing report: %0d errors in %0d checks", errors, checks);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   endtask

   //////////////////////////////
   // main sequence
   initial begin : main
      int fd;
      bit ok;
      bit got;
      i_rst_n  = 1'b0;
      i_set    = '0;
      i_pps    = 1'b0;
      i_run_rx = 1'b0;
      i_event  = '0;
      count_budget(ok);
      if (!ok) begin
         $display("could not open the test file %s", tests_file);
         errors++;
      end else begin
         repeat (reset_cycles) @(negedge bus_clk);
         i_rst_n = 1'b1;
         fd  = $fopen(tests_file, "r");
         got = 1'b1;
         while (got) begin
            read_step(fd, got);
            if (got)
               run_step();
         end
         $fclose(fd);
      end
      finish_run();
   end

   initial begin : watchdog
      wait (cycle_limit > 0);
      while (cycle_count < cycle_limit) begin
         @(posedge bus_clk);
         cycle_count++;
      end
      $display("timeout: test file not finished after %0d cycles", cycle_count);
      errors++;
      finish_run();
   end

endmodule

`default_nettype wire

// ==== tb/radio_ctrl_tests.txt ====
# one step per line, numbers in hex: w addr data | e flags state code rate len run_rx
# p pps_level | i idle_cycles | c rb_sel user_sel expected_rb_data
# event flags from the MSB: power_trigger short long pkt_begin ht fcs_stb fcs_ok byte_stb
c 0 0 0000000000000000
w 15 cafef00d
c 0 0 00000000cafef00d
# immediate time load then ten idle cycles
w 80 00000012
w 81 3456789a
w 82 00000001
i a
c 1 0 00000012345678a5
# load armed for the next pps rise, then a second rise for the latch
w 80 00000100
w 81 00000000
w 82 00000002
i 2
p 1
i 4
c 1 0 0000010000000005
p 0
i 3
p 1
c 2 0 000001000000000a
p 0
# receiver events
e 80 2 1 00 0000 1
e 20 5 3 00 0000 1
e 18 3 2 00 0000 1
c 7 1 000000000000359d
e 01 4 0 2c 05dc 1
e 06 1 1 1a ffff 1
c 7 1 0000002c05dc35fd
# status clear, user readback, then resume
w fd 00000001
c 7 1 0000000000000000
c 7 0 0000000000000001
w fd 00000000
e 04 7 9 00 0000 1
c 7 1 00000000000097a0
c 7 2 0000000000000000
c 4 0 0000000000000000
